/* hw/ext_dev_pkg.sv */
// Common types, memory depth and register map for the external device subsystem
// RTL blocks reference these by scoped name
package ext_dev_pkg;

  // Data path widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  be_t;

  // Register bus byte offset
  typedef logic [4:0] regaddr_t;

  // Word index into the slow memory
  typedef logic [6:0] mem_idx_t;

  localparam int unsigned NUM_WORDS = 128;

  // Register map of the copy peripheral
  localparam regaddr_t REG_SRC    = 5'h00;
  localparam regaddr_t REG_DST    = 5'h04;
  localparam regaddr_t REG_SIZE   = 5'h08;
  localparam regaddr_t REG_CTRL   = 5'h0c;
  localparam regaddr_t REG_STATUS = 5'h10;

  // Bit positions inside CTRL and STATUS
  localparam int unsigned CTRL_START_BIT  = 0;
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

  // Copy engine FSM
  typedef enum logic [2:0] {
    CP_IDLE,
    CP_RD_REQ,
    CP_RD_WAIT,
    CP_WR_REQ,
    CP_WR_WAIT
  } copy_state_t;

endpackage

/* hw/slow_memory.sv */
// OBI memory that stalls each request by 0 to 3 extra cycles before the grant
// Response comes one cycle after the grant, for reads and for writes
`timescale 1ns/1ns

module slow_memory (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  logic               we_i,
  input  ext_dev_pkg::addr_t addr_i,
  input  ext_dev_pkg::word_t wdata_i,
  input  ext_dev_pkg::be_t   be_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output ext_dev_pkg::word_t rdata_o
);

  ext_dev_pkg::word_t    mem_q [ext_dev_pkg::NUM_WORDS];
  ext_dev_pkg::mem_idx_t idx;
  ext_dev_pkg::word_t    rdata_q;
  logic [7:0]            lfsr_q;
  logic [1:0]            wait_q;
  logic                  pending_q;
  logic                  rvalid_q;

  assign idx = addr_i[8:2];

  // Grant once the wait count has run out
  assign gnt_o    = req_i && pending_q && (wait_q == 2'd0);
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lfsr_q    <= 8'ha5;
      wait_q    <= 2'd0;
      pending_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      // x^8 + x^6 + x^5 + x^4 + 1, free running
      lfsr_q   <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      rvalid_q <= gnt_o;
      if (!pending_q) begin
        if (req_i) begin
          pending_q <= 1'b1;
          wait_q    <= lfsr_q[1:0];
        end
      end else if (gnt_o) begin
        pending_q <= 1'b0;
      end else if (wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  // Storage and read data, sampled at the grant
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      rdata_q <= mem_q[idx];
    end
  end

  // A waiting request stays up until its grant
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_i && !gnt_o |=> req_i);

endmodule

/* hw/obi_arbiter.sv */
// Shares one OBI device between two hosts with alternating priority
// Host 0 is the external port, host 1 the copy engine
`timescale 1ns/1ns

module obi_arbiter (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               h0_req_i,
  input  logic               h0_we_i,
  input  ext_dev_pkg::addr_t h0_addr_i,
  input  ext_dev_pkg::word_t h0_wdata_i,
  input  ext_dev_pkg::be_t   h0_be_i,
  output logic               h0_gnt_o,
  output logic               h0_rvalid_o,
  output ext_dev_pkg::word_t h0_rdata_o,
  input  logic               h1_req_i,
  input  logic               h1_we_i,
  input  ext_dev_pkg::addr_t h1_addr_i,
  input  ext_dev_pkg::word_t h1_wdata_i,
  input  ext_dev_pkg::be_t   h1_be_i,
  output logic               h1_gnt_o,
  output logic               h1_rvalid_o,
  output ext_dev_pkg::word_t h1_rdata_o,
  output logic               dev_req_o,
  output logic               dev_we_o,
  output ext_dev_pkg::addr_t dev_addr_o,
  output ext_dev_pkg::word_t dev_wdata_o,
  output ext_dev_pkg::be_t   dev_be_o,
  input  logic               dev_gnt_i,
  input  logic               dev_rvalid_i,
  input  ext_dev_pkg::word_t dev_rdata_i
);

  logic rr_q;
  logic lock_q;
  logic owner_q;
  logic sel;

  // rr_q set means host 1 has priority
  always_comb begin
    if (lock_q) begin
      sel = owner_q;
    end else if (rr_q) begin
      sel = h1_req_i || !h0_req_i;
    end else begin
      sel = h1_req_i && !h0_req_i;
    end
  end

  // No new request reaches the device while a response is outstanding
  assign dev_req_o   = !lock_q && (sel ? h1_req_i : h0_req_i);
  assign dev_we_o    = sel ? h1_we_i : h0_we_i;
  assign dev_addr_o  = sel ? h1_addr_i : h0_addr_i;
  assign dev_wdata_o = sel ? h1_wdata_i : h0_wdata_i;
  assign dev_be_o    = sel ? h1_be_i : h0_be_i;

  assign h0_gnt_o    = dev_gnt_i && !lock_q && !sel;
  assign h1_gnt_o    = dev_gnt_i && !lock_q && sel;
  assign h0_rvalid_o = dev_rvalid_i && lock_q && !owner_q;
  assign h1_rvalid_o = dev_rvalid_i && lock_q && owner_q;
  assign h0_rdata_o  = owner_q ? '0 : dev_rdata_i;
  assign h1_rdata_o  = owner_q ? dev_rdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q    <= 1'b0;
      lock_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (!lock_q && dev_gnt_i) begin
      lock_q  <= 1'b1;
      owner_q <= sel;
    end else if (lock_q && dev_rvalid_i) begin
      lock_q <= 1'b0;
      // The other host goes first next time
      rr_q   <= !owner_q;
    end
  end

  // A response goes back only to the host granted one cycle earlier
  assert property (@(posedge clk_i) disable iff (reset_i)
    h0_rvalid_o |-> $past(h0_gnt_o));
  assert property (@(posedge clk_i) disable iff (reset_i)
    h1_rvalid_o |-> $past(h1_gnt_o));

endmodule

/* hw/memcopy_engine.sv */
// Word copy engine, one OBI read then one OBI write per word
// Pulses done_o once the last write has been acknowledged
`timescale 1ns/1ns

module memcopy_engine (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  ext_dev_pkg::addr_t src_i,
  input  ext_dev_pkg::addr_t dst_i,
  input  logic [7:0]         size_i,
  output logic               busy_o,
  output logic               done_o,
  output logic               master_req_o,
  output logic               master_we_o,
  output ext_dev_pkg::addr_t master_addr_o,
  output ext_dev_pkg::word_t master_wdata_o,
  output ext_dev_pkg::be_t   master_be_o,
  input  logic               master_gnt_i,
  input  logic               master_rvalid_i,
  input  ext_dev_pkg::word_t master_rdata_i
);

  ext_dev_pkg::copy_state_t state_q;
  ext_dev_pkg::copy_state_t state_d;
  ext_dev_pkg::addr_t       src_q;
  ext_dev_pkg::addr_t       dst_q;
  ext_dev_pkg::word_t       data_q;
  logic [7:0]               cnt_q;
  logic                     done_q;
  logic                     done_d;

  assign busy_o = (state_q != ext_dev_pkg::CP_IDLE);
  assign done_o = done_q;

  assign master_req_o   = (state_q == ext_dev_pkg::CP_RD_REQ) ||
                          (state_q == ext_dev_pkg::CP_WR_REQ);
  assign master_we_o    = (state_q == ext_dev_pkg::CP_WR_REQ);
  assign master_addr_o  = master_we_o ? dst_q : src_q;
  assign master_wdata_o = data_q;
  assign master_be_o    = 4'hf;

  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    case (state_q)
      ext_dev_pkg::CP_IDLE: begin
        if (start_i) begin
          // Empty copy finishes straight away
          if (size_i == 8'd0) begin
            done_d = 1'b1;
          end else begin
            state_d = ext_dev_pkg::CP_RD_REQ;
          end
        end
      end
      ext_dev_pkg::CP_RD_REQ: begin
        if (master_gnt_i) begin
          state_d = ext_dev_pkg::CP_RD_WAIT;
        end
      end
      ext_dev_pkg::CP_RD_WAIT: begin
        if (master_rvalid_i) begin
          state_d = ext_dev_pkg::CP_WR_REQ;
        end
      end
      ext_dev_pkg::CP_WR_REQ: begin
        if (master_gnt_i) begin
          state_d = ext_dev_pkg::CP_WR_WAIT;
        end
      end
      ext_dev_pkg::CP_WR_WAIT: begin
        if (master_rvalid_i) begin
          if (cnt_q == 8'd1) begin
            state_d = ext_dev_pkg::CP_IDLE;
            done_d  = 1'b1;
          end else begin
            state_d = ext_dev_pkg::CP_RD_REQ;
          end
        end
      end
      default: state_d = ext_dev_pkg::CP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ext_dev_pkg::CP_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  // Addresses, word count and the word in flight
  always_ff @(posedge clk_i) begin
    if (state_q == ext_dev_pkg::CP_IDLE && start_i) begin
      src_q <= src_i;
      dst_q <= dst_i;
      cnt_q <= size_i;
    end
    if (state_q == ext_dev_pkg::CP_RD_WAIT && master_rvalid_i) begin
      data_q <= master_rdata_i;
    end
    if (state_q == ext_dev_pkg::CP_WR_WAIT && master_rvalid_i) begin
      src_q <= src_q + 32'd4;
      dst_q <= dst_q + 32'd4;
      cnt_q <= cnt_q - 8'd1;
    end
  end

  // Request held steady until the arbiter and memory grant it
  assert property (@(posedge clk_i) disable iff (reset_i)
    master_req_o && !master_gnt_i |=>
      master_req_o && $stable(master_addr_o) && $stable(master_we_o));

endmodule

/* hw/memcopy_periph.sv */
// Register-bus front end of the copy engine with a sticky done interrupt
// Software sets SRC, DST and SIZE, writes CTRL to start, clears done in STATUS
`timescale 1ns/1ns

module memcopy_periph (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  ext_dev_pkg::regaddr_t reg_addr_i,
  input  ext_dev_pkg::word_t    reg_wdata_i,
  output logic                  reg_ready_o,
  output ext_dev_pkg::word_t    reg_rdata_o,
  output logic                  reg_error_o,
  output logic                  master_req_o,
  output logic                  master_we_o,
  output ext_dev_pkg::addr_t    master_addr_o,
  output ext_dev_pkg::word_t    master_wdata_o,
  output ext_dev_pkg::be_t      master_be_o,
  input  logic                  master_gnt_i,
  input  logic                  master_rvalid_i,
  input  ext_dev_pkg::word_t    master_rdata_i,
  output logic                  intr_o
);

  ext_dev_pkg::addr_t src_q;
  ext_dev_pkg::addr_t dst_q;
  logic [7:0]         size_q;
  logic               ready_q;
  logic               start_q;
  logic               done_q;
  ext_dev_pkg::word_t rdata_q;
  logic               error_q;
  logic               access;
  logic               wr_en;
  logic               hit;
  ext_dev_pkg::word_t rd_value;
  logic               eng_busy;
  logic               eng_done;

  // Accept once per request, the ready cycle blocks a second accept
  assign access = reg_valid_i && !ready_q;
  assign wr_en  = access && reg_write_i;

  assign reg_ready_o = ready_q;
  assign reg_rdata_o = rdata_q;
  assign reg_error_o = error_q;
  assign intr_o      = done_q;

  always_comb begin
    hit      = 1'b1;
    rd_value = '0;
    case (reg_addr_i)
      ext_dev_pkg::REG_SRC:  rd_value = src_q;
      ext_dev_pkg::REG_DST:  rd_value = dst_q;
      ext_dev_pkg::REG_SIZE: rd_value = {24'd0, size_q};
      // Start bit is not stored
      ext_dev_pkg::REG_CTRL: rd_value = '0;
      ext_dev_pkg::REG_STATUS: begin
        rd_value[ext_dev_pkg::STATUS_BUSY_BIT] = eng_busy;
        rd_value[ext_dev_pkg::STATUS_DONE_BIT] = done_q;
      end
      default: hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
      src_q   <= '0;
      dst_q   <= '0;
      size_q  <= '0;
    end else begin
      ready_q <= access;
      // Start while a copy runs is dropped
      start_q <= wr_en && (reg_addr_i == ext_dev_pkg::REG_CTRL) &&
                 reg_wdata_i[ext_dev_pkg::CTRL_START_BIT] && !eng_busy && !start_q;
      if (wr_en) begin
        case (reg_addr_i)
          ext_dev_pkg::REG_SRC:  src_q  <= reg_wdata_i;
          ext_dev_pkg::REG_DST:  dst_q  <= reg_wdata_i;
          ext_dev_pkg::REG_SIZE: size_q <= reg_wdata_i[7:0];
          default: ;
        endcase
      end
      // A new completion wins over a clear in the same cycle
      if (eng_done) begin
        done_q <= 1'b1;
      end else if (wr_en && (reg_addr_i == ext_dev_pkg::REG_STATUS) &&
                   reg_wdata_i[ext_dev_pkg::STATUS_DONE_BIT]) begin
        done_q <= 1'b0;
      end
    end
  end

  // Response data, returned with the ready pulse
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= reg_write_i ? '0 : rd_value;
      error_q <= !hit;
    end
  end

  memcopy_engine memcopy_engine_i (
    .clk_i,
    .reset_i,
    .start_i        (start_q),
    .src_i          (src_q),
    .dst_i          (dst_q),
    .size_i         (size_q),
    .busy_o         (eng_busy),
    .done_o         (eng_done),
    .master_req_o,
    .master_we_o,
    .master_addr_o,
    .master_wdata_o,
    .master_be_o,
    .master_gnt_i,
    .master_rvalid_i,
    .master_rdata_i
  );

  // Host must still be holding its request when the pulse arrives
  assert property (@(posedge clk_i) disable iff (reset_i)
    reg_ready_o |-> reg_valid_i && $past(reg_valid_i));

endmodule

/* hw/ext_dev_subsystem.sv */
// Top level of the external device example: copy peripheral, arbiter, slow memory
// The external OBI host and the register bus come in from the CPU side
`timescale 1ns/1ns

module ext_dev_subsystem (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  host_req_i,
  input  logic                  host_we_i,
  input  ext_dev_pkg::addr_t    host_addr_i,
  input  ext_dev_pkg::word_t    host_wdata_i,
  input  ext_dev_pkg::be_t      host_be_i,
  output logic                  host_gnt_o,
  output logic                  host_rvalid_o,
  output ext_dev_pkg::word_t    host_rdata_o,
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  ext_dev_pkg::regaddr_t reg_addr_i,
  input  ext_dev_pkg::word_t    reg_wdata_i,
  output logic                  reg_ready_o,
  output ext_dev_pkg::word_t    reg_rdata_o,
  output logic                  reg_error_o,
  output logic                  intr_o
);

  // Copy engine host port
  logic               eng_req;
  logic               eng_we;
  ext_dev_pkg::addr_t eng_addr;
  ext_dev_pkg::word_t eng_wdata;
  ext_dev_pkg::be_t   eng_be;
  logic               eng_gnt;
  logic               eng_rvalid;
  ext_dev_pkg::word_t eng_rdata;

  // Arbiter to memory
  logic               mem_req;
  logic               mem_we;
  ext_dev_pkg::addr_t mem_addr;
  ext_dev_pkg::word_t mem_wdata;
  ext_dev_pkg::be_t   mem_be;
  logic               mem_gnt;
  logic               mem_rvalid;
  ext_dev_pkg::word_t mem_rdata;

  memcopy_periph memcopy_periph_i (
    .clk_i,
    .reset_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_ready_o,
    .reg_rdata_o,
    .reg_error_o,
    .master_req_o   (eng_req),
    .master_we_o    (eng_we),
    .master_addr_o  (eng_addr),
    .master_wdata_o (eng_wdata),
    .master_be_o    (eng_be),
    .master_gnt_i   (eng_gnt),
    .master_rvalid_i(eng_rvalid),
    .master_rdata_i (eng_rdata),
    .intr_o
  );

  obi_arbiter obi_arbiter_i (
    .clk_i,
    .reset_i,
    .h0_req_i   (host_req_i),
    .h0_we_i    (host_we_i),
    .h0_addr_i  (host_addr_i),
    .h0_wdata_i (host_wdata_i),
    .h0_be_i    (host_be_i),
    .h0_gnt_o   (host_gnt_o),
    .h0_rvalid_o(host_rvalid_o),
    .h0_rdata_o (host_rdata_o),
    .h1_req_i   (eng_req),
    .h1_we_i    (eng_we),
    .h1_addr_i  (eng_addr),
    .h1_wdata_i (eng_wdata),
    .h1_be_i    (eng_be),
    .h1_gnt_o   (eng_gnt),
    .h1_rvalid_o(eng_rvalid),
    .h1_rdata_o (eng_rdata),
    .dev_req_o  (mem_req),
    .dev_we_o   (mem_we),
    .dev_addr_o (mem_addr),
    .dev_wdata_o(mem_wdata),
    .dev_be_o   (mem_be),
    .dev_gnt_i  (mem_gnt),
    .dev_rvalid_i(mem_rvalid),
    .dev_rdata_i(mem_rdata)
  );

  slow_memory slow_ram_i (
    .clk_i,
    .reset_i,
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .gnt_o   (mem_gnt),
    .rvalid_o(mem_rvalid),
    .rdata_o (mem_rdata)
  );

endmodule

/* sim/tb_ext_dev.sv */
// Table-driven testbench for the external device subsystem
// Drives the host OBI port and the register bus, checks against a shadow memory
`timescale 1ns/1ns

module tb_ext_dev;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int GNT_TIMEOUT = 200;
  localparam int RSP_TIMEOUT = 10;
  localparam int REG_TIMEOUT = 10;
  localparam int IRQ_TIMEOUT = 5000;

  typedef enum logic [2:0] {
    OP_HWRITE,
    OP_HREAD,
    OP_RWRITE,
    OP_RREAD,
    OP_WAIT_INTR,
    OP_QUIET,
    OP_COPY_TRAFFIC
  } op_kind_t;

  // a is a word index or register offset, n a count, d data or expected data
  typedef struct packed {
    op_kind_t    kind;
    logic [31:0] a;
    logic [31:0] n;
    logic [31:0] d;
    logic [3:0]  be;
    logic        err;
  } op_t;

  logic                  clk;
  logic                  reset;
  logic                  host_req;
  logic                  host_we;
  ext_dev_pkg::addr_t    host_addr;
  ext_dev_pkg::word_t    host_wdata;
  ext_dev_pkg::be_t      host_be;
  logic                  host_gnt;
  logic                  host_rvalid;
  ext_dev_pkg::word_t    host_rdata;
  logic                  reg_valid;
  logic                  reg_write;
  ext_dev_pkg::regaddr_t reg_addr;
  ext_dev_pkg::word_t    reg_wdata;
  logic                  reg_ready;
  ext_dev_pkg::word_t    reg_rdata;
  logic                  reg_error;
  logic                  intr;

  op_t                ops[$];
  ext_dev_pkg::word_t shadow [ext_dev_pkg::NUM_WORDS];
  logic [31:0]        lfsr_state;
  ext_dev_pkg::addr_t model_src;
  ext_dev_pkg::addr_t model_dst;
  logic [7:0]         model_size;
  logic               model_busy;
  int                 value_errors;
  int                 timeouts;

  ext_dev_subsystem dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_be_i    (host_be),
    .host_gnt_o   (host_gnt),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_ready_o  (reg_ready),
    .reg_rdata_o  (reg_rdata),
    .reg_error_o  (reg_error),
    .intr_o       (intr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      value_errors++;
      $display("Error: time %0t ns, %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic ext_dev_pkg::word_t next_random_word();
    logic               fb;
    ext_dev_pkg::word_t w;
    w = '0;
    for (int k = 0; k < 32; k++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      w          = {w[30:0], fb};
    end
    return w;
  endfunction

  function automatic ext_dev_pkg::word_t merge_bytes(input ext_dev_pkg::word_t old_w,
                                                     input ext_dev_pkg::word_t new_w,
                                                     input ext_dev_pkg::be_t be);
    ext_dev_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // One OBI transfer: request until grant, then take the response
  task automatic host_access(input logic we, input logic [6:0] idx,
                             input ext_dev_pkg::word_t wdata, input ext_dev_pkg::be_t be,
                             output ext_dev_pkg::word_t rdata);
    int   cycles;
    logic got;
    @(posedge clk);
    #DRIVE_DELAY;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = {23'd0, idx, 2'b00};
    host_wdata = wdata;
    host_be    = be;
    cycles     = 0;
    got        = 1'b0;
    while (!got && cycles < GNT_TIMEOUT) begin
      @(negedge clk);
      if (host_gnt) got = 1'b1;
      else cycles++;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    host_req = 1'b0;
    rdata    = '0;
    if (!got) begin
      timeouts++;
      $display("Timeout: host request to word %0d was never granted", idx);
    end else begin
      cycles = 0;
      got    = 1'b0;
      while (!got && cycles < RSP_TIMEOUT) begin
        @(negedge clk);
        if (host_rvalid) begin
          got   = 1'b1;
          rdata = host_rdata;
        end else begin
          cycles++;
        end
      end
      if (!got) begin
        timeouts++;
        $display("Timeout: no host response for word %0d after its grant", idx);
      end else begin
        // Response belongs in the cycle right after the grant
        check_value("host_rvalid_o wait cycles", 32'(cycles), 32'd0);
      end
    end
  endtask

  // One register access, with a check that ready pulses only once
  task automatic reg_access(input logic write, input ext_dev_pkg::regaddr_t addr,
                            input ext_dev_pkg::word_t wdata,
                            output ext_dev_pkg::word_t rdata, output logic err);
    int   cycles;
    logic got;
    @(posedge clk);
    #DRIVE_DELAY;
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    cycles    = 0;
    got       = 1'b0;
    rdata     = '0;
    err       = 1'b0;
    while (!got && cycles < REG_TIMEOUT) begin
      @(negedge clk);
      if (reg_ready) begin
        got   = 1'b1;
        rdata = reg_rdata;
        err   = reg_error;
      end else begin
        cycles++;
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    reg_valid = 1'b0;
    @(negedge clk);
    if (!got) begin
      timeouts++;
      $display("Timeout: register access at offset %h never got ready", addr);
    end else begin
      // Ready comes in the cycle after valid is first seen
      check_value("reg_ready_o wait cycles", 32'(cycles), 32'd1);
      check_value("reg_ready_o after pulse", 32'(reg_ready), 32'd0);
    end
  endtask

  // Expected effect of a register write, with the copy applied at start
  task automatic model_register_write(input ext_dev_pkg::regaddr_t addr,
                                      input ext_dev_pkg::word_t d);
    logic [6:0] s_idx;
    logic [6:0] d_idx;
    case (addr)
      ext_dev_pkg::REG_SRC:  model_src  = d;
      ext_dev_pkg::REG_DST:  model_dst  = d;
      ext_dev_pkg::REG_SIZE: model_size = d[7:0];
      ext_dev_pkg::REG_CTRL: begin
        if (d[0] && !model_busy) begin
          for (int i = 0; i < int'(model_size); i++) begin
            s_idx = model_src[8:2] + 7'(i);
            d_idx = model_dst[8:2] + 7'(i);
            shadow[d_idx] = shadow[s_idx];
          end
          model_busy = (model_size != 8'd0);
        end
      end
      default: ;
    endcase
  endtask

  task automatic write_register(input ext_dev_pkg::regaddr_t addr,
                                input ext_dev_pkg::word_t d, input logic exp_err);
    ext_dev_pkg::word_t rd;
    logic               err;
    reg_access(1'b1, addr, d, rd, err);
    check_value($sformatf("reg_error_o on write to %h", addr), 32'(err), 32'(exp_err));
    model_register_write(addr, d);
  endtask

  task automatic host_write_words(input logic [31:0] base, input logic [31:0] count,
                                  input ext_dev_pkg::be_t be);
    ext_dev_pkg::word_t w;
    ext_dev_pkg::word_t rd;
    logic [6:0]         idx;
    for (int i = 0; i < int'(count); i++) begin
      idx = 7'(base + 32'(i));
      w = next_random_word();
      host_access(1'b1, idx, w, be, rd);
      shadow[idx] = merge_bytes(shadow[idx], w, be);
    end
  endtask

  task automatic host_read_words(input logic [31:0] base, input logic [31:0] count);
    ext_dev_pkg::word_t rd;
    logic [6:0]         idx;
    for (int i = 0; i < int'(count); i++) begin
      idx = 7'(base + 32'(i));
      host_access(1'b0, idx, '0, 4'h0, rd);
      check_value($sformatf("host_rdata_o word %0d", idx), rd, shadow[idx]);
    end
  endtask

  task automatic run_op(input op_t op);
    ext_dev_pkg::word_t rd;
    logic               err;
    int                 cycles;
    case (op.kind)
      OP_HWRITE: host_write_words(op.a, op.n, op.be);
      OP_HREAD:  host_read_words(op.a, op.n);
      OP_RWRITE: write_register(5'(op.a), op.d, op.err);
      OP_RREAD: begin
        reg_access(1'b0, 5'(op.a), '0, rd, err);
        check_value($sformatf("reg_rdata_o at %h", op.a), rd, op.d);
        check_value($sformatf("reg_error_o at %h", op.a), 32'(err), 32'(op.err));
      end
      OP_WAIT_INTR: begin
        cycles = 0;
        while (!intr && cycles < IRQ_TIMEOUT) begin
          @(negedge clk);
          cycles++;
        end
        if (!intr) begin
          timeouts++;
          $display("Timeout: copy never raised the interrupt");
        end
        model_busy = 1'b0;
      end
      OP_QUIET: begin
        for (int i = 0; i < int'(op.n); i++) begin
          @(negedge clk);
          check_value("intr_o", 32'(intr), 32'd0);
        end
      end
      OP_COPY_TRAFFIC: begin
        // Host traffic overlaps the copy started here
        write_register(ext_dev_pkg::REG_CTRL, 32'h1, 1'b0);
        host_write_words(op.a, op.n, op.be);
        host_read_words(op.a, op.n);
      end
      default: ;
    endcase
  endtask

  task automatic add_op(input op_kind_t kind, input logic [31:0] a, input logic [31:0] n,
                        input logic [31:0] d, input logic [3:0] be, input logic err);
    op_t o;
    o.kind = kind;
    o.a    = a;
    o.n    = n;
    o.d    = d;
    o.be   = be;
    o.err  = err;
    ops.push_back(o);
  endtask

  task automatic build_table;
    // Fill memory, then mixed byte enables over words 0 to 15
    add_op(OP_HWRITE, 0, 128, 0, 4'hf, 1'b0);
    add_op(OP_HWRITE, 0, 4, 0, 4'h1, 1'b0);
    add_op(OP_HWRITE, 4, 4, 0, 4'h6, 1'b0);
    add_op(OP_HWRITE, 8, 4, 0, 4'hc, 1'b0);
    add_op(OP_HWRITE, 12, 4, 0, 4'h9, 1'b0);
    add_op(OP_HREAD, 0, 16, 0, 4'h0, 1'b0);
    // Register readback and the unmapped offset
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_SRC), 0, 32'hdeadbee0, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_SRC), 0, 32'hdeadbee0, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_SRC), 0, 32'h0, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_DST), 0, 32'h100, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_SIZE), 0, 32'd16, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'h14, 0, 32'h55aa55aa, 4'h0, 1'b1);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_SRC), 0, 32'h0, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_DST), 0, 32'h100, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_SIZE), 0, 32'd16, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'h14, 0, 32'h0, 4'h0, 1'b1);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h0, 4'h0, 1'b0);
    // Copy words 0..15 to 64..79
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_CTRL), 0, 32'h1, 4'h0, 1'b0);
    add_op(OP_WAIT_INTR, 0, 0, 0, 4'h0, 1'b0);
    add_op(OP_HREAD, 64, 16, 0, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h2, 4'h0, 1'b0);
    // Clear done, then an empty copy
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h2, 4'h0, 1'b0);
    add_op(OP_QUIET, 0, 4, 0, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h0, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_SIZE), 0, 32'd0, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_CTRL), 0, 32'h1, 4'h0, 1'b0);
    add_op(OP_WAIT_INTR, 0, 0, 0, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h2, 4'h0, 1'b0);
    add_op(OP_HREAD, 0, 128, 0, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h2, 4'h0, 1'b0);
    // 32-word copy to words 32..63 with host traffic on 100..110
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_DST), 0, 32'h80, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_SIZE), 0, 32'd32, 4'h0, 1'b0);
    add_op(OP_COPY_TRAFFIC, 100, 11, 0, 4'hb, 1'b0);
    add_op(OP_WAIT_INTR, 0, 0, 0, 4'h0, 1'b0);
    add_op(OP_HREAD, 32, 32, 0, 4'h0, 1'b0);
    add_op(OP_HREAD, 100, 11, 0, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h2, 4'h0, 1'b0);
    // Second start while busy must be dropped
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_SRC), 0, 32'h40, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_DST), 0, 32'h140, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_SIZE), 0, 32'd16, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_CTRL), 0, 32'h1, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_CTRL), 0, 32'h1, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h1, 4'h0, 1'b0);
    add_op(OP_WAIT_INTR, 0, 0, 0, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h2, 4'h0, 1'b0);
    add_op(OP_RWRITE, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h2, 4'h0, 1'b0);
    add_op(OP_QUIET, 0, 300, 0, 4'h0, 1'b0);
    add_op(OP_RREAD, 32'(ext_dev_pkg::REG_STATUS), 0, 32'h0, 4'h0, 1'b0);
    add_op(OP_HREAD, 0, 128, 0, 4'h0, 1'b0);
  endtask

  initial begin
    reset        = 1'b1;
    host_req     = 1'b0;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    host_be      = '0;
    reg_valid    = 1'b0;
    reg_write    = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    lfsr_state   = 32'hf5294471;
    model_src    = '0;
    model_dst    = '0;
    model_size   = '0;
    model_busy   = 1'b0;
    value_errors = 0;
    timeouts     = 0;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    build_table();
    foreach (ops[k]) begin
      run_op(ops[k]);
    end
    $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
hw/ext_dev_pkg.sv
hw/slow_memory.sv
hw/obi_arbiter.sv
hw/memcopy_engine.sv
hw/memcopy_periph.sv
hw/ext_dev_subsystem.sv
sim/tb_ext_dev.sv

/* run.sh */
#!/bin/sh
# Build and run the external device testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_ext_dev -o tb_ext_dev

out=$(./obj_dir/tb_ext_dev)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TEST RESULT: PASS'; then
  exit 0
fi
exit 1
